// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Widths of the processor and bus sides
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int SEL_W  = DATA_W / 8;

    // Line geometry
    localparam int LINE_BYTES = 64;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);  // 6 bits
    localparam int BEATS      = LINE_BYTES / SEL_W;  // 8 beats per line
    localparam int BEAT_W     = $clog2(BEATS);

    localparam int UNCACHED_BIT = 31;  // Set means bypass

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [SEL_W-1:0]  sel;
        logic              we;
    } cpu_req_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_out_t;

    typedef enum logic [1:0] {
        BUS_LINE_RD   = 2'd0,
        BUS_LINE_WR   = 2'd1,
        BUS_SINGLE_RD = 2'd2,
        BUS_SINGLE_WR = 2'd3
    } bus_op_e;

    // Expands a byte select into a full bit mask
    function automatic logic [DATA_W-1:0] lane_mask(input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] mask;
        for (int i = 0; i < SEL_W; i++) begin
            mask[8*i +: 8] = {8{sel[i]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: src/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store import dcache_pkg::*; #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = ADDR_W - OFFSET_W - IDX_W
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic              i_fill_tag,
    input  wire logic [ADDR_W-1:0] i_fill_addr,
    input  wire logic              i_kill,
    output logic                   o_hit,
    output logic                   o_valid,
    output logic [TAG_W-1:0]       o_victim_tag
);

    logic [TAG_W-1:0]     tags [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = i_addr[OFFSET_W +: IDX_W];
    assign wr_idx = i_fill_addr[OFFSET_W +: IDX_W];

    assign o_valid      = valid_q[rd_idx];
    assign o_victim_tag = tags[rd_idx];  // Tag of whatever sits there now
    assign o_hit        = o_valid && (tags[rd_idx] == i_addr[ADDR_W-1 -: TAG_W]);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= '0;
        end else if (i_fill_tag) begin
            valid_q[wr_idx] <= 1'b1;
        end else if (i_kill) begin
            valid_q[wr_idx] <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fill_tag)
            tags[wr_idx] <= i_fill_addr[ADDR_W-1 -: TAG_W];
    end

endmodule

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store import dcache_pkg::*; #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  wire logic              i_clk,
    input  wire logic [ADDR_W-1:0] i_addr,
    // Processor side store
    input  wire logic              i_store,
    input  wire logic [DATA_W-1:0] i_wdata,
    input  wire logic [SEL_W-1:0]  i_sel,
    // Fill beats from the bus
    input  wire logic              i_beat_valid,
    input  wire logic [BEAT_W-1:0] i_beat_idx,
    input  wire logic [DATA_W-1:0] i_beat_data,
    // Write-back read port
    input  wire logic [BEAT_W-1:0] i_rd_beat_idx,
    output logic [DATA_W-1:0]      o_rdata,
    output logic [DATA_W-1:0]      o_wb_word
);

    localparam int WORDS = NUM_LINES * BEATS;

    logic [DATA_W-1:0] words [WORDS];

    logic [IDX_W-1:0]        line_idx;
    logic [IDX_W+BEAT_W-1:0] word_addr;
    logic [IDX_W+BEAT_W-1:0] fill_addr;
    logic [IDX_W+BEAT_W-1:0] wb_addr;

    assign line_idx  = i_addr[OFFSET_W +: IDX_W];
    assign word_addr = {line_idx, i_addr[OFFSET_W-1 -: BEAT_W]};
    assign fill_addr = {line_idx, i_beat_idx};
    assign wb_addr   = {line_idx, i_rd_beat_idx};

    ////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_beat_valid) begin
            words[fill_addr] <= i_beat_data;  // Whole word per beat
        end else if (i_store) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (i_sel[b])
                    words[word_addr][8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////

    // Lanes outside sel read back as zero
    assign o_rdata   = words[word_addr] & lane_mask(i_sel);
    assign o_wb_word = words[wb_addr];

endmodule

`default_nettype wire

// File: src/wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_master import dcache_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    // Job interface from the controller
    input  wire logic              i_bus_req,
    input  wire bus_op_e           i_bus_op,
    input  wire logic [ADDR_W-1:0] i_bus_addr,
    input  wire logic [DATA_W-1:0] i_bus_wdata,
    input  wire logic [SEL_W-1:0]  i_bus_sel,
    // Line store ports
    input  wire logic [DATA_W-1:0] i_wb_word,
    output logic [BEAT_W-1:0]      o_rd_beat_idx,
    output logic                   o_beat_valid,
    output logic [BEAT_W-1:0]      o_beat_idx,
    output logic [DATA_W-1:0]      o_beat_data,
    output logic                   o_bus_done,
    // Wishbone
    output wb_out_t                o_wb,
    input  wire logic [DATA_W-1:0] i_wb_dat,
    input  wire logic              i_wb_ack
);

    logic              cyc_q, stb_q, we_q;
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic [SEL_W-1:0]  sel_q;
    bus_op_e           op_q;
    logic [BEAT_W-1:0] cnt_q;

    logic start, beat_end, last_beat, line_op, req_line;

    assign req_line  = (i_bus_op == BUS_LINE_RD) || (i_bus_op == BUS_LINE_WR);
    assign line_op   = (op_q == BUS_LINE_RD) || (op_q == BUS_LINE_WR);
    assign start     = i_bus_req && !cyc_q && !o_bus_done;
    assign beat_end  = stb_q && i_wb_ack;
    assign last_beat = !line_op || (cnt_q == BEAT_W'(BEATS - 1));

    // Next word the line store should present
    assign o_rd_beat_idx = cyc_q ? cnt_q + BEAT_W'(1) : '0;

    assign o_wb = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q, sel: sel_q};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cyc_q        <= 1'b0;
            stb_q        <= 1'b0;
            we_q         <= 1'b0;
            o_bus_done   <= 1'b0;
            o_beat_valid <= 1'b0;
        end else begin
            o_beat_valid <= beat_end && (op_q == BUS_LINE_RD);
            if (start) begin
                cyc_q <= 1'b1;
                stb_q <= 1'b1;
                we_q  <= (i_bus_op == BUS_LINE_WR) || (i_bus_op == BUS_SINGLE_WR);
            end else if (beat_end && last_beat) begin
                cyc_q      <= 1'b0;
                stb_q      <= 1'b0;
                we_q       <= 1'b0;
                o_bus_done <= 1'b1;
            end else if (o_bus_done && !i_bus_req) begin
                o_bus_done <= 1'b0;  // Four-phase release
            end
        end
    end

    // Address, data and beat payload
    always_ff @(posedge i_clk) begin
        if (start) begin
            op_q  <= i_bus_op;
            cnt_q <= '0;
            adr_q <= req_line ? {i_bus_addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)} : i_bus_addr;
            sel_q <= req_line ? '1 : i_bus_sel;
            dat_q <= (i_bus_op == BUS_LINE_WR) ? i_wb_word : i_bus_wdata;
        end else if (beat_end) begin
            o_beat_idx  <= cnt_q;
            o_beat_data <= i_wb_dat;  // Also holds single-read data
            if (!last_beat) begin
                cnt_q <= cnt_q + BEAT_W'(1);
                adr_q <= adr_q + ADDR_W'(SEL_W);
                if (op_q == BUS_LINE_WR)
                    dat_q <= i_wb_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int  NUM_LINES = 64,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = ADDR_W - OFFSET_W - IDX_W
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    // Processor handshake
    input  wire logic              i_req,
    input  wire cpu_req_t          i_cpu,
    output logic                   o_ack,
    output logic [DATA_W-1:0]      o_rdata,
    // Tag and line store
    input  wire logic              i_hit,
    input  wire logic              i_valid,
    input  wire logic [TAG_W-1:0]  i_victim_tag,
    input  wire logic [DATA_W-1:0] i_line_rdata,
    // Bus master job
    input  wire logic              i_bus_done,
    input  wire logic [DATA_W-1:0] i_bus_rdata,
    output logic                   o_bus_req,
    output bus_op_e                o_bus_op,
    output logic [ADDR_W-1:0]      o_bus_addr,
    // Array updates
    output logic                   o_store,
    output logic                   o_fill_tag,
    output logic                   o_kill
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_MERGE,
        ST_UNCACHED,
        ST_RESPOND
    } state_e;

    state_e state;

    logic              uncached;
    logic [IDX_W-1:0]  idx;
    logic [ADDR_W-1:0] victim_addr;
    logic [ADDR_W-1:0] line_addr;

    assign uncached    = i_cpu.addr[UNCACHED_BIT];
    assign idx         = i_cpu.addr[OFFSET_W +: IDX_W];
    assign victim_addr = {i_victim_tag, idx, OFFSET_W'(0)};
    assign line_addr   = {i_cpu.addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};

    // One-cycle strobes into the arrays
    assign o_store    = i_cpu.we && ((state == ST_LOOKUP && i_hit) || state == ST_MERGE);
    assign o_kill     = (state == ST_WRITEBACK) && o_bus_req && i_bus_done;
    assign o_fill_tag = (state == ST_FILL) && o_bus_req && i_bus_done;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= ST_IDLE;
            o_ack     <= 1'b0;
            o_bus_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req && uncached) begin
                        o_bus_req <= 1'b1;
                        state     <= ST_UNCACHED;
                    end else if (i_req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (i_hit) begin
                        state <= ST_RESPOND;
                    end else if (i_valid) begin
                        o_bus_req <= 1'b1;  // Dirty victim goes out first
                        state     <= ST_WRITEBACK;
                    end else begin
                        state <= ST_FILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (i_bus_done) begin
                        o_bus_req <= 1'b0;
                        state     <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    // Wait for the previous job to release done
                    if (!o_bus_req && !i_bus_done) begin
                        o_bus_req <= 1'b1;
                    end else if (o_bus_req && i_bus_done) begin
                        o_bus_req <= 1'b0;
                        state     <= ST_MERGE;
                    end
                end
                ST_MERGE: state <= ST_RESPOND;
                ST_UNCACHED: begin
                    if (i_bus_done) begin
                        o_bus_req <= 1'b0;
                        state     <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (!o_ack) begin
                        o_ack <= 1'b1;
                    end else if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Job parameters and response data
    always_ff @(posedge i_clk) begin
        case (state)
            ST_IDLE: begin
                o_bus_op   <= i_cpu.we ? BUS_SINGLE_WR : BUS_SINGLE_RD;
                o_bus_addr <= i_cpu.addr;
            end
            ST_LOOKUP: begin
                o_rdata    <= i_line_rdata;  // Only kept on a hit
                o_bus_op   <= BUS_LINE_WR;
                o_bus_addr <= victim_addr;
            end
            ST_FILL: begin
                o_bus_op   <= BUS_LINE_RD;
                o_bus_addr <= line_addr;
            end
            ST_MERGE: o_rdata <= i_line_rdata;
            ST_UNCACHED: begin
                if (i_bus_done)
                    o_rdata <= i_bus_rdata & lane_mask(i_cpu.sel);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int NUM_LINES = 64
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire logic              i_req,
    input  wire cpu_req_t          i_cpu,
    output logic                   o_ack,
    output logic [DATA_W-1:0]      o_rdata,
    output wb_out_t                o_wb,
    input  wire logic [DATA_W-1:0] i_wb_dat,
    input  wire logic              i_wb_ack
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    logic              hit, valid, store, fill_tag, kill;
    logic [TAG_W-1:0]  victim_tag;
    logic [DATA_W-1:0] line_rdata, wb_word, beat_data;
    logic              bus_req, bus_done, beat_valid;
    bus_op_e           bus_op;
    logic [ADDR_W-1:0] bus_addr, array_addr;
    logic [BEAT_W-1:0] rd_beat_idx, beat_idx;

    // Bus jobs address the line they move, else the request word
    assign array_addr = bus_req ? bus_addr : i_cpu.addr;

    dcache_ctrl #(.NUM_LINES(NUM_LINES)) ctrl0 (
        .i_clk, .i_reset, .i_req, .i_cpu, .o_ack, .o_rdata,
        .i_hit(hit), .i_valid(valid), .i_victim_tag(victim_tag),
        .i_line_rdata(line_rdata), .i_bus_done(bus_done), .i_bus_rdata(beat_data),
        .o_bus_req(bus_req), .o_bus_op(bus_op), .o_bus_addr(bus_addr),
        .o_store(store), .o_fill_tag(fill_tag), .o_kill(kill)
    );

    tag_store #(.NUM_LINES(NUM_LINES)) tags0 (
        .i_clk, .i_reset, .i_addr(i_cpu.addr),
        .i_fill_tag(fill_tag), .i_fill_addr(bus_addr), .i_kill(kill),
        .o_hit(hit), .o_valid(valid), .o_victim_tag(victim_tag)
    );

    line_store #(.NUM_LINES(NUM_LINES)) lines0 (
        .i_clk, .i_addr(array_addr),
        .i_store(store), .i_wdata(i_cpu.wdata), .i_sel(i_cpu.sel),
        .i_beat_valid(beat_valid), .i_beat_idx(beat_idx), .i_beat_data(beat_data),
        .i_rd_beat_idx(rd_beat_idx), .o_rdata(line_rdata), .o_wb_word(wb_word)
    );

    wb_master bus0 (
        .i_clk, .i_reset,
        .i_bus_req(bus_req), .i_bus_op(bus_op), .i_bus_addr(bus_addr),
        .i_bus_wdata(i_cpu.wdata), .i_bus_sel(i_cpu.sel),
        .i_wb_word(wb_word), .o_rd_beat_idx(rd_beat_idx),
        .o_beat_valid(beat_valid), .o_beat_idx(beat_idx), .o_beat_data(beat_data),
        .o_bus_done(bus_done), .o_wb, .i_wb_dat, .i_wb_ack
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import dcache_pkg::*; #(
    parameter logic [DATA_W-1:0] MEM_BASE = '0
) (
    input  wire logic         i_clk,
    input  wire logic         i_reset,
    input  wire wb_out_t      i_wb,
    output logic [DATA_W-1:0] o_dat,
    output logic              o_ack
);

    localparam int WORDS = 512;  // 4 KB of 64-bit words

    logic [DATA_W-1:0] mem [WORDS];
    logic [8:0]        widx;
    logic              armed;
    int                wait_left;
    int                seed;
    int                write_beats;  // Bus write beats seen so far

    assign widx = i_wb.adr[11:3];

    initial begin
        seed        = 24;
        write_beats = 0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = MEM_BASE + DATA_W'(i * 8);  // Own byte address plus base
        end
    end

    // Zero to three wait cycles per beat, then a one-cycle ack
    always @(posedge i_clk) begin : respond
        int delay;
        if (i_reset) begin
            o_ack <= 1'b0;
            o_dat <= '0;
            armed <= 1'b0;
        end else if (o_ack) begin
            o_ack <= 1'b0;
        end else if (i_wb.cyc && i_wb.stb) begin
            delay = armed ? wait_left : ($unsigned($random(seed)) % 4);
            if (delay == 0) begin
                o_ack <= 1'b1;
                armed <= 1'b0;
                o_dat <= mem[widx];
                if (i_wb.we) begin
                    for (int b = 0; b < SEL_W; b++) begin
                        if (i_wb.sel[b])
                            mem[widx][8*b +: 8] <= i_wb.dat[8*b +: 8];
                    end
                    write_beats <= write_beats + 1;
                end
            end else begin
                wait_left <= delay - 1;
                armed     <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/dcache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assert import dcache_pkg::*; (
    input wire logic    i_clk,
    input wire logic    i_reset,
    input wire logic    i_req,
    input wire logic    i_ack,
    input wire wb_out_t i_wb,
    input wire logic    i_wb_ack
);

    int fail_count = 0;  // Read by the testbench at the end

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb.stb |-> i_wb.cyc)
    else begin
        fail_count++;
        $error("stb high while cyc is low");
    end

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_ack) |-> $past(i_req))
    else begin
        fail_count++;
        $error("o_ack rose without i_req");
    end

    beat_held: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb.stb && !i_wb_ack |=> i_wb.stb && $stable(i_wb.adr)
                                  && $stable(i_wb.dat) && $stable(i_wb.sel))
    else begin
        fail_count++;
        $error("Bus beat changed before ack");
    end

endmodule

bind dcache_top dcache_assert assert0 (
    .i_clk(i_clk), .i_reset(i_reset), .i_req(i_req), .i_ack(o_ack),
    .i_wb(o_wb), .i_wb_ack(i_wb_ack)
);

`default_nettype wire

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int          NUM_LINES  = 16;    // 1 KB cache below a 4 KB memory
    localparam int          HIT_CYCLES = 2;
    localparam int          MAX_CYCLES = 4000;  // About ten times the longest run
    localparam logic [63:0] MEM_BASE   = 64'h5A00_0000_0000_0000;

    logic        clk, reset, req, ack, wb_ack;
    cpu_req_t    cpu;
    wb_out_t     wb;
    logic [63:0] rdata, wb_dat;
    logic [63:0] view [512];     // What cached loads should see
    logic [63:0] backing [512];  // What memory should hold
    int          errors, checks, cycles, lat, wb0;

    dcache_top #(.NUM_LINES(NUM_LINES)) dut0 (
        .i_clk(clk), .i_reset(reset), .i_req(req), .i_cpu(cpu), .o_ack(ack),
        .o_rdata(rdata), .o_wb(wb), .i_wb_dat(wb_dat), .i_wb_ack(wb_ack)
    );

    tb_mem_model #(.MEM_BASE(MEM_BASE)) mem0 (
        .i_clk(clk), .i_reset(reset), .i_wb(wb), .o_dat(wb_dat), .o_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference rules and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [8:0] word_index(input logic [31:0] addr);
        return addr[11:3];  // Memory wraps at 4 KB
    endfunction

    function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] wdata,
                                          input logic [7:0] sel);
        logic [63:0] m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{sel[i]}};
        end
        return (old & ~m) | (wdata & m);
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // One four-phase access; latency counts edges after the sampling edge
    task automatic access(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                          input logic [7:0] sel, output logic [63:0] data, output int n_lat);
        int n;
        @(negedge clk);
        cpu = '{addr: addr, wdata: wdata, sel: sel, we: we};
        req = 1'b1;
        n = 0;
        while (!ack) begin
            @(negedge clk);
            n++;
        end
        data  = rdata;
        n_lat = n - 1;
        req   = 1'b0;
        while (ack) @(negedge clk);
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [63:0] wdata,
                              input logic [7:0] sel, output int n_lat);
        logic [63:0] unused;
        access(1'b1, addr, wdata, sel, unused, n_lat);
        view[word_index(addr)] = merge(view[word_index(addr)], wdata, sel);
        if (addr[UNCACHED_BIT])
            backing[word_index(addr)] = merge(backing[word_index(addr)], wdata, sel);
    endtask

    task automatic load_check(input string what, input logic [31:0] addr,
                              input logic [7:0] sel, output int n_lat);
        logic [63:0] d;
        logic [63:0] exp;
        access(1'b0, addr, 64'h0, sel, d, n_lat);
        exp = addr[UNCACHED_BIT] ? backing[word_index(addr)] : view[word_index(addr)];
        check_value(what, d, merge(64'h0, exp, sel));
    endtask

    // The evicted line should now sit in memory as the cache held it
    task automatic check_write_back(input string what, input logic [31:0] addr);
        logic [8:0] w;
        for (int i = 0; i < 8; i++) begin
            w = {addr[11:6], 3'(i)};
            backing[w] = view[w];
            check_value(what, mem0.mem[w], backing[w]);
        end
    endtask

    task automatic test_done(input string name, input int e0);
        $display("%-22s %s", name, (errors == e0) ? "ok" : "FAIL");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_value("o_ack after reset", ack, 0);
        check_value("cyc after reset", wb.cyc, 0);
        check_value("stb after reset", wb.stb, 0);
        check_value("we after reset", wb.we, 0);
        test_done("reset state", e0);
    endtask

    task automatic test_load_miss_hit();
        int e0;
        e0 = errors;
        load_check("miss load 0x58", 32'h58, 8'h0F, lat);
        load_check("hit load 0x40", 32'h40, 8'hFF, lat);
        check_value("hit latency 0x40", lat, HIT_CYCLES);
        load_check("hit load 0x78", 32'h78, 8'hFF, lat);
        check_value("hit latency 0x78", lat, HIT_CYCLES);
        test_done("load miss and hit", e0);
    endtask

    task automatic test_store_hit();
        int e0;
        e0  = errors;
        wb0 = mem0.write_beats;
        store_word(32'h48, 64'hDEAD_BEEF_0BAD_F00D, 8'hF0, lat);
        check_value("store hit latency", lat, HIT_CYCLES);
        load_check("merged load 0x48", 32'h48, 8'hFF, lat);
        check_value("memory 0x48 kept", mem0.mem[word_index(32'h48)], backing[9]);
        check_value("bus writes on store hit", mem0.write_beats - wb0, 0);
        test_done("store hit merge", e0);
    endtask

    task automatic test_eviction();
        int e0;
        e0 = errors;
        store_word(32'h60, 64'h0123_4567_89AB_CDEF, 8'h3C, lat);
        wb0 = mem0.write_beats;
        load_check("conflict load 0x460", 32'h460, 8'hFF, lat);
        check_value("write-back beats", mem0.write_beats - wb0, 8);
        check_write_back("evicted line 0x40", 32'h40);
        load_check("reload 0x60", 32'h60, 8'hFF, lat);
        load_check("reload 0x48", 32'h48, 8'hFF, lat);
        test_done("eviction", e0);
    endtask

    task automatic test_store_miss();
        int e0;
        e0  = errors;
        wb0 = mem0.write_beats;
        store_word(32'hA8, 64'hCAFE_0000_0000_00BE, 8'h81, lat);
        check_value("write-back on invalid line", mem0.write_beats - wb0, 0);
        load_check("store miss merged 0xA8", 32'hA8, 8'hFF, lat);
        load_check("filled word 0x80", 32'h80, 8'hFF, lat);
        check_value("memory 0xA8 kept", mem0.mem[word_index(32'hA8)],
                    backing[word_index(32'hA8)]);
        test_done("store miss", e0);
    endtask

    task automatic test_uncached();
        int e0;
        e0  = errors;
        wb0 = mem0.write_beats;
        store_word(32'h8000_0C10, 64'h1111_2222_3333_4444, 8'h0F, lat);
        check_value("uncached write beats", mem0.write_beats - wb0, 1);
        check_value("memory 0xC10", mem0.mem[word_index(32'hC10)],
                    backing[word_index(32'hC10)]);
        load_check("uncached load 0xC10", 32'h8000_0C10, 8'hFF, lat);
        store_word(32'hA8, 64'h7777_8888_9999_AAAA, 8'hFF, lat);  // Dirty cached copy
        load_check("uncached load 0xA8", 32'h8000_00A8, 8'hFF, lat);
        load_check("cached load 0xA8", 32'hA8, 8'hFF, lat);
        test_done("uncached access", e0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        reset  = 1'b1;
        req    = 1'b0;
        cpu    = '0;
        for (int i = 0; i < 512; i++) begin
            view[i]    = MEM_BASE + 64'(i * 8);
            backing[i] = view[i];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset();
        test_load_miss_hit();
        test_store_hit();
        test_eviction();
        test_store_miss();
        test_uncached();

        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, dut0.assert0.fail_count);
        if (errors == 0 && dut0.assert0.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/dcache_pkg.sv
src/tag_store.sv
src/line_store.sv
src/wb_master.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_mem_model.sv
testbench/dcache_assert.sv
testbench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/tag_store.sv
  - src/line_store.sv
  - src/wb_master.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - testbench/tb_mem_model.sv
      - testbench/dcache_assert.sv
      - testbench/tb_dcache.sv
